// File: build.f
common/rf_pkg.sv
regfile/reg2in.sv
regfile/rf_write_sel.sv
regfile/rf_read_mux.sv
regfile/rfm2.sv
design/rf_decode.sv
design/rf_exec.sv
design/rf_core_top.sv
verif/rf_core_chk.sv
verif/rf_core_tb.sv

// File: common/rf_pkg.sv
`default_nettype none

package rf_pkg;

   // ===================================================================
   // register addressing
   // ===================================================================
   typedef logic [3:0] rf_addr_t;

   // fixed roles in the register file
   localparam rf_addr_t RF_PC   = 4'd15;
   localparam rf_addr_t RF_LINK = 4'd14;

   // ===================================================================
   // instruction encoding
   // ===================================================================
   typedef enum logic [3:0] {
      OP_ADD  = 4'h0,
      OP_SUB  = 4'h1,
      OP_AND  = 4'h2,
      OP_XOR  = 4'h3,
      OP_ADDP = 4'h4,
      OP_ADDI = 4'h5,
      OP_MOVI = 4'h6,
      OP_JL   = 4'h7
   } rf_op_e;

   // register-register form
   typedef struct packed {
      rf_op_e      op;
      rf_addr_t    rd;
      rf_addr_t    ra;
      rf_addr_t    rb;
      logic [15:0] pad;
   } rf_instr_rr_t;

   // register-immediate form, op/rd/ra sit at the same bits as above
   typedef struct packed {
      rf_op_e      op;
      rf_addr_t    rd;
      rf_addr_t    ra;
      logic [3:0]  pad;
      logic [15:0] imm;
   } rf_instr_ri_t;

   typedef union packed {
      rf_instr_rr_t rr;
      rf_instr_ri_t ri;
   } rf_instr_u;

endpackage

`default_nettype wire

// File: design/rf_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rf_core_top #(
   parameter int WIDTH = 32
) (
   input  logic              clk,
   input  logic              arst_n,
   input  rf_pkg::rf_instr_u instr,
   input  logic              instr_valid,
   input  rf_pkg::rf_addr_t  probe_addr,
   output logic [WIDTH-1:0]  probe_data,
   output logic [WIDTH-1:0]  pc
);

   import rf_pkg::*;

   rf_op_e           op;
   rf_addr_t         ra;
   rf_addr_t         rb;
   rf_addr_t         rd;
   logic [15:0]      imm;
   logic             fn_wb;
   logic             fn_ra_change;
   logic             fn_link;
   logic             fn_inc_pc;
   logic [WIDTH-1:0] da;
   logic [WIDTH-1:0] db;
   logic [WIDTH-1:0] dd;
   logic [WIDTH-1:0] wb_data;
   logic [WIDTH-1:0] ra_changed;

   // ===================================================================
   // decode and execute
   // ===================================================================
   rf_decode u_decode (
      .instr        (instr),
      .instr_valid  (instr_valid),
      .op           (op),
      .ra           (ra),
      .rb           (rb),
      .rd           (rd),
      .imm          (imm),
      .fn_wb        (fn_wb),
      .fn_ra_change (fn_ra_change),
      .fn_link      (fn_link),
      .fn_inc_pc    (fn_inc_pc)
   );

   rf_exec #(.WIDTH(WIDTH)) u_exec (
      .op         (op),
      .imm        (imm),
      .da         (da),
      .db         (db),
      .dd         (dd),
      .wb_data    (wb_data),
      .ra_changed (ra_changed)
   );

   // ===================================================================
   // register file, read port t serves the debug probe
   // ===================================================================
   rfm2 #(.WIDTH(WIDTH)) u_rfm2 (
      .clk          (clk),
      .arst_n       (arst_n),
      .ra           (ra),
      .rb           (rb),
      .rd           (rd),
      .rt           (probe_addr),
      .fn_inc_pc    (fn_inc_pc),
      .fn_link      (fn_link),
      .fn_ra_change (fn_ra_change),
      .fn_wb        (fn_wb),
      .wb_data      (wb_data),
      .ra_changed   (ra_changed),
      .da           (da),
      .db           (db),
      .dd           (dd),
      .dt           (probe_data),
      .pc           (pc)
   );

endmodule

`default_nettype wire

// File: design/rf_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rf_decode (
   input  rf_pkg::rf_instr_u instr,
   input  logic              instr_valid,
   output rf_pkg::rf_op_e    op,
   output rf_pkg::rf_addr_t  ra,
   output rf_pkg::rf_addr_t  rb,
   output rf_pkg::rf_addr_t  rd,
   output logic [15:0]       imm,
   output logic              fn_wb,
   output logic              fn_ra_change,
   output logic              fn_link,
   output logic              fn_inc_pc
);

   import rf_pkg::*;

   // op lives at the same bits in both forms
   assign op = instr.rr.op;

   // immediate opcodes read imm from the ri form and have no rb
   always_comb begin
      ra  = instr.rr.ra;
      rb  = instr.rr.rb;
      rd  = instr.rr.rd;
      imm = '0;
      case (op)
         OP_ADDI, OP_MOVI: begin
            rb  = '0;
            imm = instr.ri.imm;
         end
         OP_JL: begin
            rb  = '0;
            rd  = RF_PC;
            imm = instr.ri.imm;
         end
         default: ;
      endcase
   end

   // all strobes stay quiet on an idle cycle
   always_comb begin
      fn_wb        = 1'b0;
      fn_ra_change = 1'b0;
      fn_link      = 1'b0;
      fn_inc_pc    = 1'b0;
      if (instr_valid) begin
         case (op)
            OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI, OP_MOVI: begin
               fn_wb     = 1'b1;
               fn_inc_pc = 1'b1;
            end
            OP_ADDP: begin
               fn_wb        = 1'b1;
               fn_ra_change = 1'b1;
               fn_inc_pc    = 1'b1;
            end
            OP_JL: begin
               fn_wb   = 1'b1;
               fn_link = 1'b1;
            end
            // unassigned opcodes only advance the pc
            default: fn_inc_pc = 1'b1;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: design/rf_exec.sv
`timescale 1ns/1ps
`default_nettype none

module rf_exec #(
   parameter int WIDTH = 32
) (
   input  rf_pkg::rf_op_e   op,
   input  logic [15:0]      imm,
   input  logic [WIDTH-1:0] da,
   input  logic [WIDTH-1:0] db,
   input  logic [WIDTH-1:0] dd,
   output logic [WIDTH-1:0] wb_data,
   output logic [WIDTH-1:0] ra_changed
);

   import rf_pkg::*;

   logic [WIDTH-1:0] imm_ext;

   // immediates are zero-extended
   assign imm_ext = WIDTH'(imm);

   always_comb begin
      case (op)
         OP_ADD:  wb_data = da + db;
         OP_SUB:  wb_data = da - db;
         OP_AND:  wb_data = da & db;
         OP_XOR:  wb_data = da ^ db;
         OP_ADDP: wb_data = da + db;
         // accumulate into the old rd
         OP_ADDI: wb_data = dd + imm_ext;
         OP_MOVI: wb_data = imm_ext;
         // jump target goes to r15
         OP_JL:   wb_data = imm_ext;
         default: wb_data = '0;
      endcase
   end

   // post-increment of ra, written through port 2
   assign ra_changed = da + WIDTH'(1);

endmodule

`default_nettype wire

// File: regfile/reg2in.sv
`timescale 1ns/1ps
`default_nettype none

module reg2in #(
   parameter int WIDTH = 32
) (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             wen1,
   input  logic             wen2,
   input  logic [WIDTH-1:0] din1,
   input  logic [WIDTH-1:0] din2,
   output logic [WIDTH-1:0] dout
);

   // port 1 wins when both ports write in the same cycle
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         dout <= '0;
      end else if (wen1) begin
         dout <= din1;
      end else if (wen2) begin
         dout <= din2;
      end
   end

endmodule

`default_nettype wire

// File: regfile/rf_read_mux.sv
`timescale 1ns/1ps
`default_nettype none

module rf_read_mux #(
   parameter int WIDTH = 32
) (
   input  logic [15:0][WIDTH-1:0] regs,
   input  rf_pkg::rf_addr_t       ra,
   input  rf_pkg::rf_addr_t       rb,
   input  rf_pkg::rf_addr_t       rd,
   input  rf_pkg::rf_addr_t       rt,
   output logic [WIDTH-1:0]       da,
   output logic [WIDTH-1:0]       db,
   output logic [WIDTH-1:0]       dd,
   output logic [WIDTH-1:0]       dt
);

   // operand ports for the execute unit
   always_comb begin
      da = regs[ra];
      db = regs[rb];
      dd = regs[rd];
   end

   // observation port
   always_comb begin
      dt = regs[rt];
   end

endmodule

`default_nettype wire

// File: regfile/rf_write_sel.sv
`timescale 1ns/1ps
`default_nettype none

module rf_write_sel #(
   parameter int WIDTH = 32
) (
   input  rf_pkg::rf_addr_t        ra,
   input  rf_pkg::rf_addr_t        rd,
   input  logic                    fn_wb,
   input  logic                    fn_ra_change,
   input  logic                    fn_link,
   input  logic                    fn_inc_pc,
   input  logic [WIDTH-1:0]        wb_data,
   input  logic [WIDTH-1:0]        r_pc,
   input  logic [WIDTH-1:0]        r_pc_link,
   output logic [15:0]             wen1,
   output logic [15:0]             wen2,
   output logic [15:0][WIDTH-1:0]  din1
);

   import rf_pkg::*;

   always_comb begin
      // plain write-back on port 1, post-increment on port 2
      for (int i = 0; i < 16; i++) begin
         wen1[i] = fn_wb && (rd == rf_addr_t'(i));
         wen2[i] = fn_ra_change && (ra == rf_addr_t'(i));
         din1[i] = wb_data;
      end

      // jump and link saves the current pc in r14
      wen1[RF_LINK] = wen1[RF_LINK] | fn_link;
      if (fn_link) begin
         din1[RF_LINK] = r_pc_link;
      end

      // pc increment overrides a write-back to r15
      wen1[RF_PC] = wen1[RF_PC] | fn_inc_pc;
      if (fn_inc_pc) begin
         din1[RF_PC] = r_pc + WIDTH'(1);
      end
   end

endmodule

`default_nettype wire

// File: regfile/rfm2.sv
`timescale 1ns/1ps
`default_nettype none

module rfm2 #(
   parameter int WIDTH = 32
) (
   input  logic             clk,
   input  logic             arst_n,
   input  rf_pkg::rf_addr_t ra,
   input  rf_pkg::rf_addr_t rb,
   input  rf_pkg::rf_addr_t rd,
   input  rf_pkg::rf_addr_t rt,
   input  logic             fn_inc_pc,
   input  logic             fn_link,
   input  logic             fn_ra_change,
   input  logic             fn_wb,
   input  logic [WIDTH-1:0] wb_data,
   input  logic [WIDTH-1:0] ra_changed,
   output logic [WIDTH-1:0] da,
   output logic [WIDTH-1:0] db,
   output logic [WIDTH-1:0] dd,
   output logic [WIDTH-1:0] dt,
   output logic [WIDTH-1:0] pc
);

   logic [15:0]            wen1;
   logic [15:0]            wen2;
   logic [15:0][WIDTH-1:0] din1;
   logic [15:0][WIDTH-1:0] regs;

   // ===================================================================
   // write side
   // ===================================================================
   rf_write_sel #(.WIDTH(WIDTH)) u_write_sel (
      .ra           (ra),
      .rd           (rd),
      .fn_wb        (fn_wb),
      .fn_ra_change (fn_ra_change),
      .fn_link      (fn_link),
      .fn_inc_pc    (fn_inc_pc),
      .wb_data      (wb_data),
      .r_pc         (regs[15]),
      .r_pc_link    (regs[15]),
      .wen1         (wen1),
      .wen2         (wen2),
      .din1         (din1)
   );

   // ===================================================================
   // register cells
   // ===================================================================
   for (genvar i = 0; i < 16; i++) begin : g_reg
      reg2in #(.WIDTH(WIDTH)) u_reg (
         .clk    (clk),
         .arst_n (arst_n),
         .wen1   (wen1[i]),
         .wen2   (wen2[i]),
         .din1   (din1[i]),
         .din2   (ra_changed),
         .dout   (regs[i])
      );
   end

   assign pc = regs[15];

   // ===================================================================
   // read side
   // ===================================================================
   rf_read_mux #(.WIDTH(WIDTH)) u_read_mux (
      .regs (regs),
      .ra   (ra),
      .rb   (rb),
      .rd   (rd),
      .rt   (rt),
      .da   (da),
      .db   (db),
      .dd   (dd),
      .dt   (dt)
   );

endmodule

`default_nettype wire

// File: verif/rf_core_chk.sv
`timescale 1ns/1ps
`default_nettype none

module rf_core_chk #(
   parameter int WIDTH = 32
) (
   input  logic             clk,
   input  logic             arst_n,
   input  logic [15:0]      wen1,
   input  logic             fn_inc_pc,
   input  logic             fn_wb,
   input  logic             fn_ra_change,
   input  rf_pkg::rf_addr_t ra,
   input  rf_pkg::rf_addr_t rd,
   input  logic [WIDTH-1:0] pc
);

   import rf_pkg::*;

   int fail_count = 0;

   // r14 and r15 may be written on top of rd, the rest only through rd
   a_wen1_onehot: assert property (@(posedge clk) disable iff (!arst_n)
      $onehot0(wen1[13:0]))
   else begin
      $error("several port-1 write enables active among r0 to r13");
      fail_count++;
   end

   a_pc_source: assert property (@(posedge clk) disable iff (!arst_n)
      (pc != $past(pc)) |->
      $past(fn_inc_pc || (fn_wb && rd == RF_PC) || (fn_ra_change && ra == RF_PC)))
   else begin
      $error("pc changed without a write strobe aimed at r15");
      fail_count++;
   end

   a_pc_step: assert property (@(posedge clk) disable iff (!arst_n)
      fn_inc_pc |=> (pc == $past(pc) + WIDTH'(1)))
   else begin
      $error("pc did not step by one after an increment strobe");
      fail_count++;
   end

endmodule

`default_nettype wire

// File: verif/rf_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rf_core_tb;

   import rf_pkg::*;

   localparam int WIDTH          = 32;
   localparam int N_RAND         = 400;
   localparam int N_TESTS        = N_RAND + 32;
   localparam int TIMEOUT_CYCLES = N_TESTS * 20 + 100;

   logic             clk;
   logic             arst_n;
   rf_instr_u        instr;
   logic             instr_valid;
   rf_addr_t         probe_addr;
   logic [WIDTH-1:0] probe_data;
   logic [WIDTH-1:0] pc;

   logic [WIDTH-1:0] model_regs [16];
   logic [31:0]      rng_state   = 32'h57cf;
   rf_addr_t         last_dest   = '0;
   int               cycle_count = 0;

   rf_core_top #(.WIDTH(WIDTH)) UUT (
      .clk         (clk),
      .arst_n      (arst_n),
      .instr       (instr),
      .instr_valid (instr_valid),
      .probe_addr  (probe_addr),
      .probe_data  (probe_data),
      .pc          (pc)
   );

   bind rfm2 rf_core_chk #(.WIDTH(WIDTH)) u_chk (
      .clk          (clk),
      .arst_n       (arst_n),
      .wen1         (wen1),
      .fn_inc_pc    (fn_inc_pc),
      .fn_wb        (fn_wb),
      .fn_ra_change (fn_ra_change),
      .ra           (ra),
      .rd           (rd),
      .pc           (pc)
   );

   always #2 clk = ~clk;

   // ======================================================================
   // reference model
   // ======================================================================
   function automatic void apply_instr(input rf_instr_u ins);
      logic [WIDTH-1:0] a;
      logic [WIDTH-1:0] b;
      logic [WIDTH-1:0] d;
      logic [WIDTH-1:0] pc_old;
      logic [WIDTH-1:0] imm_ext;
      a       = model_regs[ins.rr.ra];
      b       = model_regs[ins.rr.rb];
      d       = model_regs[ins.rr.rd];
      pc_old  = model_regs[15];
      imm_ext = WIDTH'(ins.ri.imm);
      case (ins.rr.op)
         OP_ADD:  model_regs[ins.rr.rd] = a + b;
         OP_SUB:  model_regs[ins.rr.rd] = a - b;
         OP_AND:  model_regs[ins.rr.rd] = a & b;
         OP_XOR:  model_regs[ins.rr.rd] = a ^ b;
         // the sum is written last so it wins when rd equals ra
         OP_ADDP: begin
            model_regs[ins.rr.ra] = a + WIDTH'(1);
            model_regs[ins.rr.rd] = a + b;
         end
         OP_ADDI: model_regs[ins.ri.rd] = d + imm_ext;
         OP_MOVI: model_regs[ins.ri.rd] = imm_ext;
         OP_JL: begin
            model_regs[14] = pc_old;
            model_regs[15] = imm_ext;
         end
         default: ;
      endcase
      // pc step beats any write-back to r15
      if (ins.rr.op != OP_JL) begin
         model_regs[15] = pc_old + WIDTH'(1);
      end
   endfunction

   function automatic rf_addr_t expected_rd(input rf_instr_u ins);
      return (ins.rr.op == OP_JL) ? RF_PC : ins.rr.rd;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   function automatic rf_instr_u make_rr(input rf_op_e op, input rf_addr_t rd,
                                         input rf_addr_t ra, input rf_addr_t rb);
      rf_instr_u ins;
      ins = '0;
      ins.rr.op = op;
      ins.rr.rd = rd;
      ins.rr.ra = ra;
      ins.rr.rb = rb;
      return ins;
   endfunction

   function automatic rf_instr_u make_ri(input rf_op_e op, input rf_addr_t rd,
                                         input logic [15:0] imm);
      rf_instr_u ins;
      ins = '0;
      ins.ri.op  = op;
      ins.ri.rd  = rd;
      ins.ri.imm = imm;
      return ins;
   endfunction

   // ======================================================================
   // checking
   // ======================================================================
   task automatic abort_run();
      $display("Test failures found");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic check_data(input string name, input logic [WIDTH-1:0] got,
                             input logic [WIDTH-1:0] exp);
      if (got !== exp) begin
         $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_addr(input string name, input rf_addr_t got, input rf_addr_t exp);
      if (got !== exp) begin
         $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
         abort_run();
      end
   endtask

   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < 16; i++) begin
            model_regs[i] = '0;
         end
      end else if (instr_valid) begin
         apply_instr(instr);
      end
   end

   // outputs settle well before the falling edge
   always @(negedge clk) begin
      if (arst_n) begin
         check_data("pc", pc, model_regs[15]);
         check_data("probe_data", probe_data, model_regs[probe_addr]);
         if (instr_valid) begin
            check_addr("UUT.rd", UUT.rd, expected_rd(instr));
         end
         if (UUT.u_rfm2.u_chk.fail_count != 0) begin
            $display("a register file assertion failed at %0t", $time);
            abort_run();
         end
      end
   end

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         abort_run();
      end
   end

   // ======================================================================
   // stimulus
   // ======================================================================
   // probe follows the destination of the previous instruction
   task automatic issue(input rf_instr_u ins);
      @(posedge clk);
      instr       <= ins;
      instr_valid <= 1'b1;
      probe_addr  <= last_dest;
      last_dest = (ins.rr.op == OP_JL) ? RF_LINK : expected_rd(ins);
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         instr_valid <= 1'b0;
         probe_addr  <= last_dest;
      end
   endtask

   task automatic probe_all();
      for (int i = 0; i < 16; i++) begin
         @(posedge clk);
         instr_valid <= 1'b0;
         probe_addr  <= rf_addr_t'(i);
      end
   endtask

   task automatic run_random(input int count);
      logic [31:0] word;
      logic [31:0] gap;
      for (int n = 0; n < count; n++) begin
         word = next_rand();
         gap  = next_rand();
         // mostly defined opcodes, a few unassigned ones
         if (gap[27:25] != 3'b000) begin
            word[31] = 1'b0;
         end
         issue(rf_instr_u'(word));
         if (gap[31:30] == 2'b11) begin
            idle(int'(gap[29:28]) + 1);
         end
      end
   endtask

   initial begin
      clk         = 1'b0;
      arst_n      = 1'b0;
      instr       = '0;
      instr_valid = 1'b0;
      probe_addr  = '0;
      repeat (10) @(posedge clk);
      arst_n <= 1'b1;

      // reset state and idle cycles
      idle(4);
      probe_all();

      // alu operations
      issue(make_ri(OP_MOVI, 4'd1, 16'h1234));
      issue(make_ri(OP_MOVI, 4'd2, 16'h0f0f));
      issue(make_rr(OP_ADD, 4'd3, 4'd1, 4'd2));
      issue(make_rr(OP_SUB, 4'd4, 4'd1, 4'd2));
      issue(make_rr(OP_SUB, 4'd5, 4'd2, 4'd1));
      issue(make_rr(OP_AND, 4'd6, 4'd1, 4'd2));
      issue(make_rr(OP_XOR, 4'd7, 4'd1, 4'd2));

      // post-increment, then rd equal to ra
      issue(make_rr(OP_ADDP, 4'd8, 4'd1, 4'd2));
      idle(1);
      issue(make_rr(OP_ADDP, 4'd3, 4'd3, 4'd4));

      // immediate accumulate
      issue(make_ri(OP_ADDI, 4'd9, 16'h0005));
      issue(make_ri(OP_ADDI, 4'd9, 16'hffff));
      issue(make_ri(OP_ADDI, 4'd9, 16'h0100));

      // jump and link, then one step from the target
      issue(make_ri(OP_JL, 4'd0, 16'h0040));
      issue(make_ri(OP_MOVI, 4'd10, 16'h00aa));
      idle(2);
      probe_all();

      run_random(N_RAND);
      idle(2);
      probe_all();
      @(posedge clk);
      @(negedge clk);

      if (UUT.u_rfm2.u_chk.fail_count == 0) begin
         $display("All tests passed!");
         $finish;
      end else begin
         $display("a register file assertion failed during the run");
         abort_run();
      end
   end

endmodule

`default_nettype wire
